//--- dv/decode_exec_cases.txt
1 3c011234 1 01 12340000 0 0
0 00000000 0 00 00000000 0 0
1 34215678 1 01 12345678 0 0
1 2402fffd 1 02 fffffffd 0 0
1 3023ff0f 1 03 00005608 0 0
1 38448001 1 04 ffff7ffc 0 0
1 28450005 1 05 00000001 0 0
1 2c460005 1 06 00000000 0 0
1 24000077 1 00 00000077 0 0
0 00000000 0 00 00000000 0 0
1 00033825 1 07 00005608 0 0
1 00615022 1 0a edcbff90 0 0
1 00224020 1 08 12345675 0 0
1 01415824 1 0b 00005610 0 0
1 00254821 1 09 12345679 0 0
1 002a6025 1 0c fffffff8 0 0
1 00236827 1 0d edcba987 0 0
1 00247026 1 0e edcb2984 0 0
1 0045782a 1 0f 00000001 0 0
1 0045802b 1 10 00000000 0 0
1 00018900 1 11 23456780 0 0
1 00029043 1 12 fffffffe 0 0
1 000a9a02 1 13 00edcbff 0 0
1 00a1a004 1 14 2468acf0 0 0
1 00eaa807 1 15 ffedcbff 0 0
1 00a2b006 1 16 7ffffffe 0 0
1 7077b820 1 17 00000011 0 0
1 7098c021 1 18 00000010 0 0
1 0026c80a 1 19 12345678 0 0
1 0025c80a 0 00 00000000 0 0
1 0065d00b 1 1a 00005608 0 0
1 0066d00b 0 00 00000000 0 0
1 00220018 0 00 00000000 0 0
1 70220000 0 00 00000000 0 0
1 0022001a 0 00 00000000 0 0
1 8c410004 0 00 00000000 0 0
1 ac410008 0 00 00000000 0 0
1 08000100 0 00 00000000 0 0
1 03e00008 0 00 00000000 0 0
1 00001810 0 00 00000000 0 0
1 40816000 0 00 00000000 0 0
1 0000000c 0 00 00000000 0 0
1 10670004 0 00 00000000 1 1
1 10230004 0 00 00000000 1 0
1 14230004 0 00 00000000 1 1
1 14670004 0 00 00000000 1 0
1 1c200004 0 00 00000000 1 1
1 1c400004 0 00 00000000 1 0
1 18000004 0 00 00000000 1 1
1 18200004 0 00 00000000 1 0
1 04400004 0 00 00000000 1 1
1 04200004 0 00 00000000 1 0
1 04010004 0 00 00000000 1 1
1 04410004 0 00 00000000 1 0
1 04500004 0 00 00000000 1 1
1 04b00004 0 00 00000000 1 0
1 241b0100 1 1b 00000100 0 0
1 0001e000 1 1c 12345678 0 0
1 037be821 1 1d 00000200 0 0
0 00000000 0 00 00000000 0 0

//--- dv/decode_exec_tb.sv
`timescale 1ns/1ps

module decode_exec_tb import isa_pkg::*, opgen_pkg::*;;

  localparam int max_reads   = 1000;
  localparam int drain_limit = 4;
  localparam int exp_w       = 1 + reg_addr_w + data_w + 2;

  logic                  clk;
  logic                  rst;
  logic [inst_w-1:0]     inst;
  logic                  inst_valid;
  logic                  wb_en;
  logic [reg_addr_w-1:0] wb_addr;
  logic [data_w-1:0]     wb_data;
  logic                  branch_valid;
  logic                  branch_taken;

  // Expected outputs of issued lines in issue order
  logic [exp_w-1:0] exp_q[$];

  int fd;
  int code;
  int line_count;
  int guard;

  logic                  c_valid;
  logic [inst_w-1:0]     c_inst;
  logic                  c_wb_en;
  logic [reg_addr_w-1:0] c_addr;
  logic [data_w-1:0]     c_data;
  logic                  c_bv;
  logic                  c_bt;

  tb_clock u_clock (
    .clk (clk)
  );

  decode_exec_top DUT (
    .clk          (clk),
    .rst          (rst),
    .inst         (inst),
    .inst_valid   (inst_valid),
    .wb_en        (wb_en),
    .wb_addr      (wb_addr),
    .wb_data      (wb_data),
    .branch_valid (branch_valid),
    .branch_taken (branch_taken)
  );

  task automatic check_value(input string name, input logic [data_w-1:0] actual,
                             input logic [data_w-1:0] expected);
    if (actual !== expected) begin
      $display("FAILED time=%0t %s actual=%h expected=%h", $time, name, actual, expected);
      $display("Test failed");
      $fatal(1, "Output mismatch on %s", name);
    end
  endtask

  // Compare the outputs against the line issued two cycles ago
  task automatic check_oldest();
    logic                  e_wb_en;
    logic [reg_addr_w-1:0] e_addr;
    logic [data_w-1:0]     e_data;
    logic                  e_bv;
    logic                  e_bt;
    {e_wb_en, e_addr, e_data, e_bv, e_bt} = exp_q.pop_front();
    check_value("wb_en", data_w'(wb_en), data_w'(e_wb_en));
    if (e_wb_en) begin
      check_value("wb_addr", data_w'(wb_addr), data_w'(e_addr));
      check_value("wb_data", wb_data, e_data);
    end
    check_value("branch_valid", data_w'(branch_valid), data_w'(e_bv));
    check_value("branch_taken", data_w'(branch_taken), data_w'(e_bt));
  endtask

  task automatic stop_with_error(input string reason);
    $display("Test failed");
    $fatal(1, "%s", reason);
  endtask

  initial begin
    rst        = 1'b1;
    inst       = '0;
    inst_valid = 1'b0;

    // No strobes while reset is held for four cycles
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      @(negedge clk);
      check_value("wb_en", data_w'(wb_en), '0);
      check_value("branch_valid", data_w'(branch_valid), '0);
    end
    rst = 1'b0;

    fd = $fopen("dv/decode_exec_cases.txt", "r");
    if (fd == 0) begin
      stop_with_error("Case file dv/decode_exec_cases.txt could not be opened");
    end

    line_count = 0;
    guard      = 0;
    while (!$feof(fd)) begin
      if (guard >= max_reads) begin
        stop_with_error("Case file did not reach its end in time");
      end
      guard++;
      code = $fscanf(fd, "%h %h %h %h %h %h %h\n",
                     c_valid, c_inst, c_wb_en, c_addr, c_data, c_bv, c_bt);
      if (code == 7) begin
        @(negedge clk);
        if (exp_q.size() >= 2) begin
          check_oldest();
        end
        inst_valid = c_valid;
        inst       = c_inst;
        exp_q.push_back({c_wb_en, c_addr, c_data, c_bv, c_bt});
        line_count++;
      end else if (!$feof(fd)) begin
        stop_with_error("Case file holds a malformed line");
      end
    end
    $fclose(fd);

    if (line_count == 0) begin
      stop_with_error("Case file holds no cases");
    end

    // Let the last two lines leave the pipeline
    guard = 0;
    while (exp_q.size() > 0) begin
      if (guard >= drain_limit) begin
        stop_with_error("Pipeline did not drain in time");
      end
      guard++;
      @(negedge clk);
      check_oldest();
      inst_valid = 1'b0;
      inst       = '0;
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

endmodule

//--- logic/decode_exec_top.sv
`timescale 1ns/1ps

module decode_exec_top import isa_pkg::*, opgen_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [inst_w-1:0]     inst,
  input  logic                  inst_valid,
  output logic                  wb_en,
  output logic [reg_addr_w-1:0] wb_addr,
  output logic [data_w-1:0]     wb_data,
  output logic                  branch_valid,
  output logic                  branch_taken
);

  logic [inst_op_w-1:0]  op;
  logic [funct_w-1:0]    funct;
  logic [reg_addr_w-1:0] rs;
  logic [reg_addr_w-1:0] rt;
  logic [opgen_w-1:0]    opgen;
  logic [data_w-1:0]     rs_data;
  logic [data_w-1:0]     rt_data;
  logic                  ex_valid;
  logic [opgen_w-1:0]    ex_op;
  logic [data_w-1:0]     ex_a;
  logic [data_w-1:0]     ex_b;
  logic [reg_addr_w-1:0] ex_dest;
  logic                  ex_dest_en;

  decode_stage u_decode (
    .clk        (clk),
    .rst        (rst),
    .inst       (inst),
    .inst_valid (inst_valid),
    .op         (op),
    .funct      (funct),
    .rs         (rs),
    .rt         (rt),
    .opgen      (opgen),
    .rs_data    (rs_data),
    .rt_data    (rt_data),
    .ex_valid   (ex_valid),
    .ex_op      (ex_op),
    .ex_a       (ex_a),
    .ex_b       (ex_b),
    .ex_dest    (ex_dest),
    .ex_dest_en (ex_dest_en)
  );

  op_gen u_op_gen (
    .op       (op),
    .funct_in (funct),
    .rs       (rs),
    .rt       (rt),
    .opgen    (opgen)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .rst     (rst),
    .rs_addr (rs),
    .rt_addr (rt),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .wb_data (wb_data)
  );

  exec_unit u_exec (
    .clk          (clk),
    .rst          (rst),
    .ex_valid     (ex_valid),
    .ex_op        (ex_op),
    .ex_a         (ex_a),
    .ex_b         (ex_b),
    .ex_dest      (ex_dest),
    .ex_dest_en   (ex_dest_en),
    .wb_en        (wb_en),
    .wb_addr      (wb_addr),
    .wb_data      (wb_data),
    .branch_valid (branch_valid),
    .branch_taken (branch_taken)
  );

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import isa_pkg::*, opgen_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  inst_word_u            inst,
  input  logic                  inst_valid,
  output logic [inst_op_w-1:0]  op,
  output logic [funct_w-1:0]    funct,
  output logic [reg_addr_w-1:0] rs,
  output logic [reg_addr_w-1:0] rt,
  input  logic [opgen_w-1:0]    opgen,
  input  logic [data_w-1:0]     rs_data,
  input  logic [data_w-1:0]     rt_data,
  output logic                  ex_valid,
  output logic [opgen_w-1:0]    ex_op,
  output logic [data_w-1:0]     ex_a,
  output logic [data_w-1:0]     ex_b,
  output logic [reg_addr_w-1:0] ex_dest,
  output logic                  ex_dest_en
);

  logic [data_w-1:0]     a_sel;
  logic [data_w-1:0]     b_sel;
  logic [reg_addr_w-1:0] dest;
  logic                  dest_en;
  logic [imm_w-1:0]      imm;

  assign op    = inst.r_fmt.op;
  assign funct = inst.r_fmt.funct;
  assign rs    = inst.r_fmt.rs;
  assign rt    = inst.r_fmt.rt;
  assign imm   = inst.i_fmt.imm16;

  always_comb begin
    a_sel   = rs_data;
    b_sel   = rt_data;
    dest    = inst.r_fmt.rd;
    dest_en = 1'b0;
    case (op)
      op_special: begin
        case (funct)
          funct_sll, funct_srl, funct_sra: begin
            a_sel   = data_w'(inst.r_fmt.shamt);
            dest_en = 1'b1;
          end
          funct_sllv, funct_srlv, funct_srav, funct_add, funct_addu,
          funct_sub, funct_subu, funct_and, funct_or, funct_xor,
          funct_nor, funct_slt, funct_sltu, funct_movz, funct_movn:
            dest_en = 1'b1;
          default: dest_en = 1'b0;
        endcase
      end
      op_special2: begin
        dest_en = (funct == funct_mul) || (funct == funct_clz) || (funct == funct_clo);
      end
      op_addi, op_addiu, op_slti, op_sltiu: begin
        b_sel   = {{(data_w-imm_w){imm[imm_w-1]}}, imm};
        dest    = rt;
        dest_en = 1'b1;
      end
      op_andi, op_ori, op_xori: begin
        b_sel   = data_w'(imm);
        dest    = rt;
        dest_en = 1'b1;
      end
      op_lui: begin
        a_sel   = '0;
        b_sel   = {imm, {(data_w-imm_w){1'b0}}};
        dest    = rt;
        dest_en = 1'b1;
      end
      default: dest_en = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid   <= 1'b0;
      ex_op      <= opgen_nop;
      ex_dest_en <= 1'b0;
    end else begin
      ex_valid <= inst_valid;
      if (inst_valid) begin
        ex_op      <= opgen;
        ex_dest_en <= dest_en;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (inst_valid) begin
      ex_a    <= a_sel;
      ex_b    <= b_sel;
      ex_dest <= dest;
    end
  end

  // Op code from op_gen must resolve for every issued word
  assert property (@(posedge clk) disable iff (rst) inst_valid |-> !$isunknown(opgen));

endmodule

//--- logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit import isa_pkg::*, opgen_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  ex_valid,
  input  logic [opgen_w-1:0]    ex_op,
  input  logic [data_w-1:0]     ex_a,
  input  logic [data_w-1:0]     ex_b,
  input  logic [reg_addr_w-1:0] ex_dest,
  input  logic                  ex_dest_en,
  output logic                  wb_en,
  output logic [reg_addr_w-1:0] wb_addr,
  output logic [data_w-1:0]     wb_data,
  output logic                  branch_valid,
  output logic                  branch_taken
);

  logic [data_w-1:0] result;
  logic              mov_ok;
  logic              is_branch;
  logic              cond;

  function automatic logic [data_w-1:0] lead_zeros(input logic [data_w-1:0] v);
    logic [data_w-1:0] n;
    logic              seen;
    n    = '0;
    seen = 1'b0;
    for (int i = data_w - 1; i >= 0; i--) begin
      if (v[i])
        seen = 1'b1;
      else if (!seen)
        n = n + 1'b1;
    end
    return n;
  endfunction

  always_comb begin
    case (ex_op)
      opgen_add:  result = ex_a + ex_b;
      opgen_sub:  result = ex_a - ex_b;
      opgen_slt:  result = data_w'($signed(ex_a) < $signed(ex_b));
      opgen_sltu: result = data_w'(ex_a < ex_b);
      opgen_and:  result = ex_a & ex_b;
      opgen_or:   result = ex_a | ex_b;
      opgen_nor:  result = ~(ex_a | ex_b);
      opgen_xor:  result = ex_a ^ ex_b;
      opgen_sll:  result = ex_b << ex_a[4:0];
      opgen_srl:  result = ex_b >> ex_a[4:0];
      opgen_sra:  result = $signed(ex_b) >>> ex_a[4:0];
      opgen_mul:  result = ex_a * ex_b;
      opgen_clz:  result = lead_zeros(ex_a);
      opgen_clo:  result = lead_zeros(~ex_a);
      opgen_movz, opgen_movn: result = ex_a;
      default:    result = '0;
    endcase
  end

  // MOVZ/MOVN gate on the b operand
  assign mov_ok = (ex_op == opgen_movz) ? (ex_b == '0) :
                  (ex_op == opgen_movn) ? (ex_b != '0) : 1'b1;

  always_comb begin
    is_branch = 1'b1;
    case (ex_op)
      opgen_beq:  cond = (ex_a == ex_b);
      opgen_bne:  cond = (ex_a != ex_b);
      opgen_bgtz: cond = ($signed(ex_a) > 0);
      opgen_blez: cond = ($signed(ex_a) <= 0);
      opgen_bltz: cond = ex_a[data_w-1];
      opgen_bgez: cond = !ex_a[data_w-1];
      default: begin
        is_branch = 1'b0;
        cond      = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_en        <= 1'b0;
      branch_valid <= 1'b0;
      branch_taken <= 1'b0;
    end else begin
      wb_en        <= ex_valid && ex_dest_en && mov_ok;
      branch_valid <= ex_valid && is_branch;
      branch_taken <= ex_valid && is_branch && cond;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid) begin
      wb_addr <= ex_dest;
      wb_data <= result;
    end
  end

  assert property (@(posedge clk) disable iff (rst) !(wb_en && branch_valid));
  assert property (@(posedge clk) disable iff (rst)
    !ex_valid |=> !wb_en && !branch_valid);

endmodule

//--- logic/isa_pkg.sv
package isa_pkg;

  localparam int inst_w     = 32;
  localparam int inst_op_w  = 6;
  localparam int funct_w    = 6;
  localparam int reg_addr_w = 5;
  localparam int imm_w      = 16;
  localparam int target_w   = 26;

  // Primary opcodes
  localparam logic [inst_op_w-1:0] op_special  = 6'h00;
  localparam logic [inst_op_w-1:0] op_regimm   = 6'h01;
  localparam logic [inst_op_w-1:0] op_j        = 6'h02;
  localparam logic [inst_op_w-1:0] op_jal      = 6'h03;
  localparam logic [inst_op_w-1:0] op_beq      = 6'h04;
  localparam logic [inst_op_w-1:0] op_bne      = 6'h05;
  localparam logic [inst_op_w-1:0] op_blez     = 6'h06;
  localparam logic [inst_op_w-1:0] op_bgtz     = 6'h07;
  localparam logic [inst_op_w-1:0] op_addi     = 6'h08;
  localparam logic [inst_op_w-1:0] op_addiu    = 6'h09;
  localparam logic [inst_op_w-1:0] op_slti     = 6'h0a;
  localparam logic [inst_op_w-1:0] op_sltiu    = 6'h0b;
  localparam logic [inst_op_w-1:0] op_andi     = 6'h0c;
  localparam logic [inst_op_w-1:0] op_ori      = 6'h0d;
  localparam logic [inst_op_w-1:0] op_xori     = 6'h0e;
  localparam logic [inst_op_w-1:0] op_lui      = 6'h0f;
  localparam logic [inst_op_w-1:0] op_cp0      = 6'h10;
  localparam logic [inst_op_w-1:0] op_special2 = 6'h1c;
  localparam logic [inst_op_w-1:0] op_lb       = 6'h20;
  localparam logic [inst_op_w-1:0] op_lh       = 6'h21;
  localparam logic [inst_op_w-1:0] op_lw       = 6'h23;
  localparam logic [inst_op_w-1:0] op_lbu      = 6'h24;
  localparam logic [inst_op_w-1:0] op_lhu      = 6'h25;
  localparam logic [inst_op_w-1:0] op_sb       = 6'h28;
  localparam logic [inst_op_w-1:0] op_sh       = 6'h29;
  localparam logic [inst_op_w-1:0] op_sw       = 6'h2b;

  // Special funct codes
  localparam logic [funct_w-1:0] funct_sll   = 6'h00;
  localparam logic [funct_w-1:0] funct_srl   = 6'h02;
  localparam logic [funct_w-1:0] funct_sra   = 6'h03;
  localparam logic [funct_w-1:0] funct_sllv  = 6'h04;
  localparam logic [funct_w-1:0] funct_srlv  = 6'h06;
  localparam logic [funct_w-1:0] funct_srav  = 6'h07;
  localparam logic [funct_w-1:0] funct_jr    = 6'h08;
  localparam logic [funct_w-1:0] funct_jalr  = 6'h09;
  localparam logic [funct_w-1:0] funct_movz  = 6'h0a;
  localparam logic [funct_w-1:0] funct_movn  = 6'h0b;
  localparam logic [funct_w-1:0] funct_mfhi  = 6'h10;
  localparam logic [funct_w-1:0] funct_mthi  = 6'h11;
  localparam logic [funct_w-1:0] funct_mflo  = 6'h12;
  localparam logic [funct_w-1:0] funct_mtlo  = 6'h13;
  localparam logic [funct_w-1:0] funct_mult  = 6'h18;
  localparam logic [funct_w-1:0] funct_multu = 6'h19;
  localparam logic [funct_w-1:0] funct_div   = 6'h1a;
  localparam logic [funct_w-1:0] funct_divu  = 6'h1b;
  localparam logic [funct_w-1:0] funct_add   = 6'h20;
  localparam logic [funct_w-1:0] funct_addu  = 6'h21;
  localparam logic [funct_w-1:0] funct_sub   = 6'h22;
  localparam logic [funct_w-1:0] funct_subu  = 6'h23;
  localparam logic [funct_w-1:0] funct_and   = 6'h24;
  localparam logic [funct_w-1:0] funct_or    = 6'h25;
  localparam logic [funct_w-1:0] funct_xor   = 6'h26;
  localparam logic [funct_w-1:0] funct_nor   = 6'h27;
  localparam logic [funct_w-1:0] funct_slt   = 6'h2a;
  localparam logic [funct_w-1:0] funct_sltu  = 6'h2b;

  // Special2 funct codes
  localparam logic [funct_w-1:0] funct_madd  = 6'h00;
  localparam logic [funct_w-1:0] funct_maddu = 6'h01;
  localparam logic [funct_w-1:0] funct_mul   = 6'h02;
  localparam logic [funct_w-1:0] funct_msub  = 6'h04;
  localparam logic [funct_w-1:0] funct_msubu = 6'h05;
  localparam logic [funct_w-1:0] funct_clz   = 6'h20;
  localparam logic [funct_w-1:0] funct_clo   = 6'h21;

  // Regimm rt codes and cp0 rs codes
  localparam logic [reg_addr_w-1:0] regimm_bltz   = 5'h00;
  localparam logic [reg_addr_w-1:0] regimm_bgez   = 5'h01;
  localparam logic [reg_addr_w-1:0] regimm_bltzal = 5'h10;
  localparam logic [reg_addr_w-1:0] regimm_bgezal = 5'h11;
  localparam logic [reg_addr_w-1:0] cp0_mfc0      = 5'h00;
  localparam logic [reg_addr_w-1:0] cp0_mtc0      = 5'h04;

  typedef struct packed {
    logic [inst_op_w-1:0]  op;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] shamt;
    logic [funct_w-1:0]    funct;
  } r_fmt_t;

  typedef struct packed {
    logic [inst_op_w-1:0]  op;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [imm_w-1:0]      imm16;
  } i_fmt_t;

  typedef struct packed {
    logic [inst_op_w-1:0] op;
    logic [target_w-1:0]  target26;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    j_fmt_t j_fmt;
  } inst_word_u;

endpackage

//--- logic/op_gen.sv
`timescale 1ns/1ps

module op_gen import isa_pkg::*, opgen_pkg::*; (
  input  logic [inst_op_w-1:0]  op,
  input  logic [funct_w-1:0]    funct_in,
  input  logic [reg_addr_w-1:0] rs,
  input  logic [reg_addr_w-1:0] rt,
  output logic [opgen_w-1:0]    opgen
);

  always_comb begin
    case (op)
      op_special: begin
        case (funct_in)
          funct_add, funct_addu:   opgen = opgen_add;
          funct_sub, funct_subu:   opgen = opgen_sub;
          funct_slt:               opgen = opgen_slt;
          funct_sltu:              opgen = opgen_sltu;
          funct_div:               opgen = opgen_div;
          funct_divu:              opgen = opgen_divu;
          funct_mult:              opgen = opgen_mult;
          funct_multu:             opgen = opgen_multu;
          funct_and:               opgen = opgen_and;
          funct_nor:               opgen = opgen_nor;
          funct_or:                opgen = opgen_or;
          funct_xor:               opgen = opgen_xor;
          funct_sll, funct_sllv:   opgen = opgen_sll;
          funct_sra, funct_srav:   opgen = opgen_sra;
          funct_srl, funct_srlv:   opgen = opgen_srl;
          funct_jr, funct_jalr:    opgen = opgen_jr;
          // HI/LO moves pass through the OR path
          funct_mfhi, funct_mflo,
          funct_mthi, funct_mtlo:  opgen = opgen_or;
          funct_movz:              opgen = opgen_movz;
          funct_movn:              opgen = opgen_movn;
          // SYSCALL, BREAK land here
          default:                 opgen = opgen_nop;
        endcase
      end
      op_special2: begin
        case (funct_in)
          funct_madd:  opgen = opgen_mult;
          funct_maddu: opgen = opgen_multu;
          funct_msub:  opgen = opgen_msub;
          funct_msubu: opgen = opgen_msubu;
          funct_mul:   opgen = opgen_mul;
          funct_clz:   opgen = opgen_clz;
          funct_clo:   opgen = opgen_clo;
          default:     opgen = opgen_nop;
        endcase
      end
      op_regimm: begin
        case (rt)
          regimm_bltz, regimm_bltzal: opgen = opgen_bltz;
          regimm_bgez, regimm_bgezal: opgen = opgen_bgez;
          default:                    opgen = opgen_nop;
        endcase
      end
      op_cp0: begin
        case (rs)
          cp0_mfc0, cp0_mtc0: opgen = opgen_or;
          default:            opgen = opgen_nop;
        endcase
      end
      op_addi, op_addiu: opgen = opgen_add;
      op_slti:           opgen = opgen_slt;
      op_sltiu:          opgen = opgen_sltu;
      op_andi:           opgen = opgen_and;
      op_lui, op_ori:    opgen = opgen_or;
      op_xori:           opgen = opgen_xor;
      op_beq:            opgen = opgen_beq;
      op_bne:            opgen = opgen_bne;
      op_bgtz:           opgen = opgen_bgtz;
      op_blez:           opgen = opgen_blez;
      op_j, op_jal:      opgen = opgen_j;
      op_lb, op_lbu, op_lh, op_lhu, op_lw,
      op_sb, op_sh, op_sw: opgen = opgen_mem;
      default:           opgen = opgen_nop;
    endcase
  end

endmodule

//--- logic/opgen_pkg.sv
package opgen_pkg;

  localparam int opgen_w = 6;
  localparam int data_w  = 32;

  localparam logic [opgen_w-1:0] opgen_nop   = 6'd0;
  localparam logic [opgen_w-1:0] opgen_add   = 6'd1;
  localparam logic [opgen_w-1:0] opgen_sub   = 6'd2;
  localparam logic [opgen_w-1:0] opgen_slt   = 6'd3;
  localparam logic [opgen_w-1:0] opgen_sltu  = 6'd4;
  localparam logic [opgen_w-1:0] opgen_and   = 6'd5;
  localparam logic [opgen_w-1:0] opgen_or    = 6'd6;
  localparam logic [opgen_w-1:0] opgen_nor   = 6'd7;
  localparam logic [opgen_w-1:0] opgen_xor   = 6'd8;
  localparam logic [opgen_w-1:0] opgen_sll   = 6'd9;
  localparam logic [opgen_w-1:0] opgen_sra   = 6'd10;
  localparam logic [opgen_w-1:0] opgen_srl   = 6'd11;
  localparam logic [opgen_w-1:0] opgen_movz  = 6'd12;
  localparam logic [opgen_w-1:0] opgen_movn  = 6'd13;
  localparam logic [opgen_w-1:0] opgen_clz   = 6'd14;
  localparam logic [opgen_w-1:0] opgen_clo   = 6'd15;
  localparam logic [opgen_w-1:0] opgen_mult  = 6'd16;
  localparam logic [opgen_w-1:0] opgen_multu = 6'd17;
  localparam logic [opgen_w-1:0] opgen_msub  = 6'd18;
  localparam logic [opgen_w-1:0] opgen_msubu = 6'd19;
  localparam logic [opgen_w-1:0] opgen_mul   = 6'd20;
  localparam logic [opgen_w-1:0] opgen_div   = 6'd21;
  localparam logic [opgen_w-1:0] opgen_divu  = 6'd22;
  localparam logic [opgen_w-1:0] opgen_beq   = 6'd23;
  localparam logic [opgen_w-1:0] opgen_bne   = 6'd24;
  localparam logic [opgen_w-1:0] opgen_bgtz  = 6'd25;
  localparam logic [opgen_w-1:0] opgen_blez  = 6'd26;
  localparam logic [opgen_w-1:0] opgen_bltz  = 6'd27;
  localparam logic [opgen_w-1:0] opgen_bgez  = 6'd28;
  localparam logic [opgen_w-1:0] opgen_j     = 6'd29;
  localparam logic [opgen_w-1:0] opgen_jr    = 6'd30;
  localparam logic [opgen_w-1:0] opgen_mem   = 6'd31;

endpackage

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import isa_pkg::*, opgen_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [reg_addr_w-1:0] rs_addr,
  input  logic [reg_addr_w-1:0] rt_addr,
  output logic [data_w-1:0]     rs_data,
  output logic [data_w-1:0]     rt_data,
  input  logic                  wb_en,
  input  logic [reg_addr_w-1:0] wb_addr,
  input  logic [data_w-1:0]     wb_data
);

  logic [data_w-1:0] regs [2**reg_addr_w];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && wb_addr != '0) begin
      regs[wb_addr] <= wb_data;
    end
  end

  // Bypass lets a reader in the write cycle see the new value
  assign rs_data = (rs_addr == '0) ? '0 :
                   (wb_en && wb_addr == rs_addr) ? wb_data : regs[rs_addr];
  assign rt_data = (rt_addr == '0) ? '0 :
                   (wb_en && wb_addr == rt_addr) ? wb_data : regs[rt_addr];

  assert property (@(posedge clk) disable iff (rst) regs[0] == '0);

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the decode/execute testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module decode_exec_tb -f sim.f -o decode_exec_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/decode_exec_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi

exit 0

//--- sim.f
logic/isa_pkg.sv
logic/opgen_pkg.sv
logic/op_gen.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/exec_unit.sv
logic/decode_exec_top.sv
dv/tb_clock.sv
dv/decode_exec_tb.sv
